// ==== compile.f ====
+incdir+include
verilog/lau_pkg.sv
verilog/axi_lite_pkg.sv
verilog/prefix_and_or.sv
verilog/add_sub.sv
verilog/lau_regs.sv
verilog/lau_top.sv
verif/tb_lau.sv

// ==== include/lau_cfg.svh ====
// configuration macros for the arithmetic unit
// word width, bus address width, register map, default prefix structure

`ifndef LAU_CFG_SVH
`define LAU_CFG_SVH

// operand and result width, one bus word
`define LAU_WIDTH 32

// axi4-lite address width
`define LAU_ADDR_W 4

// register byte offsets
`define LAU_REG_A    4'h0
`define LAU_REG_B    4'h4
`define LAU_REG_CTRL 4'h8
`define LAU_REG_RES  4'hC

// default carry tree, sklansky
`define LAU_SPEED_DEFAULT lau_pkg::FAST

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the arithmetic unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lau -f compile.f -o tb_lau

status=0
out=$(./obj_dir/tb_lau) || status=$?
echo "$out"

if grep -Fxq '** PASS **' <<< "$out"; then
	exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

// ==== verif/tb_lau.sv ====
// testbench for the arithmetic unit
// axi4-lite write and read tasks with back-pressure and timeouts
// reference model for add and subtract and a result checker process
// reset, directed, random, readback, read-only and back-pressure tests

`include "lau_cfg.svh"

module tb_lau;
	import axi_lite_pkg::*;

	// one result read waiting for comparison
	typedef struct packed {
		logic [`LAU_WIDTH-1:0] a;
		logic [`LAU_WIDTH-1:0] b;
		logic                  sub;
		logic [`LAU_WIDTH-1:0] got;
	} res_item_t;

	logic          clk;
	logic          rst_n;
	axi_lite_req_t req;
	axi_lite_rsp_t rsp;

	res_item_t   res_q[$];
	string       cur_test;
	int          errors;
	int          test_start_errors;
	int          tests_passed;
	int          tests_failed;
	bit          hung;

	lau_top i_lau_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.axi_req (req),
		.axi_rsp (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// expected sum or difference wrapping at the word width
	function automatic logic [`LAU_WIDTH-1:0] ref_add_sub(input logic [`LAU_WIDTH-1:0] a,
			input logic [`LAU_WIDTH-1:0] b, input logic sub);
		if (sub) begin
			return a - b;
		end
		return a + b;
	endfunction

	task automatic report_failure(input string what);
		$display("%s: %s", cur_test, what);
		errors++;
	endtask

	// after a stuck bus the later bus tasks skip
	task automatic report_hang(input string what);
		report_failure({"timed out waiting for ", what});
		hung = 1'b1;
	endtask

	task automatic expect_eq(input string label, input logic [31:0] expected,
			input logic [31:0] actual);
		if (!hung) begin
			assert (actual === expected) else begin
				$display("error %s %s: expected %h, actual %h", cur_test, label, expected, actual);
				errors++;
			end
		end
	endtask

	// called and returns at the drive point
	// hold keeps b ready low for that many cycles after b valid
	task automatic axi_write(input logic [`LAU_ADDR_W-1:0] addr, input logic [`LAU_WIDTH-1:0] data,
			input int hold, output logic [1:0] resp);
		int n;
		int i;
		resp = 2'b00;
		if (hung) return;
		req.aw_valid = 1'b1;
		req.aw_addr  = addr;
		req.w_valid  = 1'b1;
		req.w_data   = data;
		req.w_strb   = '1;
		req.b_ready  = (hold == 0);
		// ready is combinational so look mid-cycle
		n = 0;
		@(negedge clk);
		while (!rsp.aw_ready && !rsp.w_ready && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.aw_ready && !rsp.w_ready) begin
			report_hang("write address and data ready");
			return;
		end
		// address and data are accepted in the same cycle
		assert (rsp.aw_ready && rsp.w_ready) else
			report_failure("aw ready and w ready did not rise together");
		@(posedge clk);
		#10;
		req.aw_valid = 1'b0;
		req.w_valid  = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rsp.b_valid && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.b_valid) begin
			report_hang("write response valid");
			return;
		end
		resp = rsp.b_resp;
		// response must sit still while the master stalls
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			assert (rsp.b_valid && rsp.b_resp == resp) else
				report_failure("write response dropped or changed while b ready was low");
		end
		if (hold > 0) begin
			@(posedge clk);
			#10;
			req.b_ready = 1'b1;
		end
		@(posedge clk);
		#10;
		req.b_ready = 1'b0;
	endtask

	// same shape as the write with r ready held low for hold cycles
	task automatic axi_read(input logic [`LAU_ADDR_W-1:0] addr, input int hold,
			output logic [`LAU_WIDTH-1:0] data, output logic [1:0] resp);
		int n;
		int i;
		data = '0;
		resp = 2'b00;
		if (hung) return;
		req.ar_valid = 1'b1;
		req.ar_addr  = addr;
		req.r_ready  = (hold == 0);
		n = 0;
		@(negedge clk);
		while (!rsp.ar_ready && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.ar_ready) begin
			report_hang("read address ready");
			return;
		end
		@(posedge clk);
		#10;
		req.ar_valid = 1'b0;
		n = 0;
		@(negedge clk);
		while (!rsp.r_valid && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!rsp.r_valid) begin
			report_hang("read data valid");
			return;
		end
		data = rsp.r_data;
		resp = rsp.r_resp;
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			assert (rsp.r_valid && rsp.r_data === data) else
				report_failure("read data dropped or changed while r ready was low");
		end
		if (hold > 0) begin
			@(posedge clk);
			#10;
			req.r_ready = 1'b1;
		end
		@(posedge clk);
		#10;
		req.r_ready = 1'b0;
	endtask

	task automatic write_ok(input logic [`LAU_ADDR_W-1:0] addr, input logic [`LAU_WIDTH-1:0] data);
		logic [1:0] resp;
		axi_write(addr, data, 0, resp);
		expect_eq("write response", 32'(OKAY), 32'(resp));
	endtask

	task automatic read_ok(input logic [`LAU_ADDR_W-1:0] addr, output logic [`LAU_WIDTH-1:0] data);
		logic [1:0] resp;
		axi_read(addr, 0, data, resp);
		expect_eq("read response", 32'(OKAY), 32'(resp));
	endtask

	// load operands and control then read the result for the checker
	task automatic run_op(input logic [`LAU_WIDTH-1:0] a, input logic [`LAU_WIDTH-1:0] b,
			input logic sub);
		logic [`LAU_WIDTH-1:0] got;
		write_ok(`LAU_REG_A, a);
		write_ok(`LAU_REG_B, b);
		write_ok(`LAU_REG_CTRL, {31'b0, sub});
		read_ok(`LAU_REG_RES, got);
		if (!hung) res_q.push_back('{a, b, sub, got});
	endtask

	task automatic start_test(input string name);
		cur_test          = name;
		test_start_errors = errors;
	endtask

	// let the checker empty its queue first
	task automatic end_test();
		int n;
		n = 0;
		while (res_q.size() > 0 && n < 10) begin
			@(posedge clk);
			#10;
			n++;
		end
		if (res_q.size() > 0) report_hang("result checker");
		if (errors == test_start_errors) begin
			$display("test %s: passed", cur_test);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", cur_test, errors - test_start_errors);
			tests_failed++;
		end
	endtask

	// compares every result read with the model
	always @(posedge clk) begin : compare_results
		res_item_t             item;
		logic [`LAU_WIDTH-1:0] expected;
		while (res_q.size() > 0) begin
			item     = res_q.pop_front();
			expected = ref_add_sub(item.a, item.b, item.sub);
			assert (item.got === expected) else begin
				$display("error %s result of %h %s %h: expected %h, actual %h", cur_test, item.a,
					item.sub ? "-" : "+", item.b, expected, item.got);
				errors++;
			end
		end
	end

	initial begin : main
		logic [`LAU_WIDTH-1:0] data;
		logic [`LAU_WIDTH-1:0] a;
		logic [`LAU_WIDTH-1:0] b;
		logic [`LAU_WIDTH-1:0] r;
		logic [1:0]            resp;
		void'($urandom(54));
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		hung         = 1'b0;
		cur_test     = "setup";
		req          = '0;
		rst_n        = 1'b0;
		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;
		@(posedge clk);
		#10;

		// registers and result come up zero
		start_test("reset");
		read_ok(`LAU_REG_A, data);
		expect_eq("a after reset", 32'h0, data);
		read_ok(`LAU_REG_B, data);
		expect_eq("b after reset", 32'h0, data);
		read_ok(`LAU_REG_CTRL, data);
		expect_eq("ctrl after reset", 32'h0, data);
		read_ok(`LAU_REG_RES, data);
		expect_eq("result after reset", 32'h0, data);
		end_test();

		// wrap-around corners
		start_test("directed");
		run_op(32'hffff_ffff, 32'h1, 1'b0);
		run_op(32'h0, 32'h1, 1'b1);
		run_op(32'h1234_5678, 32'h1234_5678, 1'b1);
		run_op(32'h7fff_ffff, 32'h1, 1'b0);
		run_op(32'h8000_0000, 32'h8000_0000, 1'b0);
		run_op(32'h5, 32'h7, 1'b1);
		end_test();

		start_test("random");
		for (int i = 0; i < 200; i++) begin
			a = $urandom();
			b = $urandom();
			r = $urandom();
			run_op(a, b, r[0]);
		end
		end_test();

		start_test("readback");
		a = $urandom();
		b = $urandom();
		write_ok(`LAU_REG_A, a);
		write_ok(`LAU_REG_B, b);
		write_ok(`LAU_REG_CTRL, 32'h1);
		read_ok(`LAU_REG_A, data);
		expect_eq("a readback", a, data);
		read_ok(`LAU_REG_B, data);
		expect_eq("b readback", b, data);
		read_ok(`LAU_REG_CTRL, data);
		expect_eq("ctrl readback", 32'h1, data);
		end_test();

		// result offset is read-only
		start_test("result write");
		run_op(32'h0000_1000, 32'h0000_0234, 1'b0);
		axi_write(`LAU_REG_RES, 32'hdead_beef, 0, resp);
		expect_eq("result write response", 32'(SLVERR), 32'(resp));
		read_ok(`LAU_REG_RES, data);
		expect_eq("result after write", 32'h0000_1234, data);
		read_ok(`LAU_REG_A, data);
		expect_eq("a after result write", 32'h0000_1000, data);
		read_ok(`LAU_REG_B, data);
		expect_eq("b after result write", 32'h0000_0234, data);
		end_test();

		// master stalls b and r for several cycles
		start_test("back-pressure");
		axi_write(`LAU_REG_A, 32'h0000_0064, 5, resp);
		expect_eq("stalled write response", 32'(OKAY), 32'(resp));
		write_ok(`LAU_REG_B, 32'h0000_00c8);
		write_ok(`LAU_REG_CTRL, 32'h1);
		axi_read(`LAU_REG_RES, 6, data, resp);
		expect_eq("stalled read response", 32'(OKAY), 32'(resp));
		if (!hung) res_q.push_back('{32'h64, 32'hc8, 1'b1, data});
		end_test();

		$display("tests: %0d passed, %0d failed, %0d check errors", tests_passed, tests_failed,
			errors);
		if (errors == 0 && !hung) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== verilog/add_sub.sv ====
// binary adder-subtractor on a parallel-prefix carry tree
// s = sub ? a - b : a + b modulo 2^width

module add_sub #(
	parameter int              width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             sub,
	output logic [width-1:0] s
);

	// b after optional inversion
	logic [width-1:0] b_inv;
	// tree inputs and group generate output
	logic [width-1:0] gi;
	logic [width-1:0] pi;
	logic [width-1:0] go;
	// half sum per bit
	logic [width-1:0] pt;

	// two's complement as inverted b plus carry-in
	assign b_inv = b ^ {width{sub}};

	// bit 0 absorbs the carry-in as a full-adder majority
	assign gi[0] = (a[0] & b_inv[0]) | (a[0] & sub) | (b_inv[0] & sub);
	assign pi[0] = 1'b0;
	assign pt[0] = a[0] ^ b_inv[0];

	for (genvar i = 1; i < width; i++) begin : g_pre
		assign gi[i] = a[i] & b_inv[i];
		assign pi[i] = a[i] | b_inv[i];
		// or without and gives the xor
		assign pt[i] = ~gi[i] & pi[i];
	end

	// carry out of every bit position
	prefix_and_or #(
		.width (width),
		.speed (speed)
	) i_prefix_and_or (
		.gi (gi),
		.pi (pi),
		.go (go),
		.po ()
	);

	// carry into bit i is the group generate of bit i-1
	assign s = pt ^ {go[width-2:0], sub};

endmodule

// ==== verilog/axi_lite_pkg.sv ====
// axi4-lite bus types
// response codes, request bundle (master to slave), response bundle

`include "lau_cfg.svh"

package axi_lite_pkg;

	// only the two codes this slave returns
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// master side of all five channels
	typedef struct packed {
		// write address
		logic                    aw_valid;
		logic [`LAU_ADDR_W-1:0]  aw_addr;
		// write data
		logic                    w_valid;
		logic [`LAU_WIDTH-1:0]   w_data;
		logic [`LAU_WIDTH/8-1:0] w_strb;
		// write response
		logic                    b_ready;
		// read address
		logic                    ar_valid;
		logic [`LAU_ADDR_W-1:0]  ar_addr;
		// read data
		logic                    r_ready;
	} axi_lite_req_t;

	// slave side of all five channels
	typedef struct packed {
		logic                  aw_ready;
		logic                  w_ready;
		// write response
		logic                  b_valid;
		resp_e                 b_resp;
		logic                  ar_ready;
		// read data
		logic                  r_valid;
		logic [`LAU_WIDTH-1:0] r_data;
		resp_e                 r_resp;
	} axi_lite_rsp_t;

endpackage

// ==== verilog/lau_pkg.sv ====
// arithmetic types
// prefix tree speed selection, control word, operand bundle

`include "lau_cfg.svh"

package lau_pkg;

	// carry tree structure
	typedef enum logic [1:0] {
		SLOW,
		MEDIUM,
		FAST
	} speed_e;

	// control register, only bit 0 has a meaning
	typedef struct packed {
		logic [`LAU_WIDTH-2:0] reserved;
		logic                  sub;
	} lau_ctrl_t;

	// operands into the adder path
	typedef struct packed {
		logic [`LAU_WIDTH-1:0] a;
		logic [`LAU_WIDTH-1:0] b;
		logic                  sub;
	} lau_operands_t;

endpackage

// ==== verilog/lau_regs.sv ====
// axi4-lite register slave for the arithmetic unit
// holds operand a, operand b and the control word
// single-beat writes and reads, one response in flight per direction
// result register is read-only, a write to it gets slverr

`include "lau_cfg.svh"

module lau_regs (
	input  logic                        clk,
	input  logic                        rst_n,
	input  axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp,
	output lau_pkg::lau_operands_t      operands,
	input  logic [`LAU_WIDTH-1:0]       result
);
	import axi_lite_pkg::*;
	import lau_pkg::*;

	// stored registers
	logic [`LAU_WIDTH-1:0] reg_a;
	logic [`LAU_WIDTH-1:0] reg_b;
	lau_ctrl_t             reg_ctrl;

	// write side
	logic  wr_fire;
	logic  b_valid;
	resp_e b_resp;

	// read side
	logic                  ar_ready;
	logic                  rd_fire;
	logic                  r_valid;
	logic [`LAU_WIDTH-1:0] r_data;
	logic [`LAU_WIDTH-1:0] rd_mux;

	// address and data taken together, blocked while b is pending
	assign wr_fire = axi_req.aw_valid & axi_req.w_valid & ~b_valid;

	// register file, strobes ignored, every write is a full word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_a    <= '0;
			reg_b    <= '0;
			reg_ctrl <= '0;
		end else if (wr_fire) begin
			case (axi_req.aw_addr)
				`LAU_REG_A:    reg_a <= axi_req.w_data;
				`LAU_REG_B:    reg_b <= axi_req.w_data;
				`LAU_REG_CTRL: reg_ctrl <= lau_ctrl_t'(axi_req.w_data);
				// result is read-only
				default: ;
			endcase
		end
	end

	// write response pending flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			b_valid <= 1'b0;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
		end else if (axi_req.b_ready) begin
			b_valid <= 1'b0;
		end
	end

	// response code latched with the write
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			b_resp <= (axi_req.aw_addr == `LAU_REG_RES) ? SLVERR : OKAY;
		end
	end

	// read source select
	always_comb begin
		case (axi_req.ar_addr)
			`LAU_REG_A:    rd_mux = reg_a;
			`LAU_REG_B:    rd_mux = reg_b;
			`LAU_REG_CTRL: rd_mux = reg_ctrl;
			`LAU_REG_RES:  rd_mux = result;
			// unaligned offsets
			default:       rd_mux = '0;
		endcase
	end

	assign rd_fire = axi_req.ar_valid & ar_ready;

	// ar ready is low in reset, then tracks the absence of a pending read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_valid  <= 1'b0;
			ar_ready <= 1'b0;
		end else if (rd_fire) begin
			r_valid  <= 1'b1;
			ar_ready <= 1'b0;
		end else if (r_valid && axi_req.r_ready) begin
			r_valid  <= 1'b0;
			ar_ready <= 1'b1;
		end else if (!r_valid) begin
			ar_ready <= 1'b1;
		end
	end

	// data sampled at the address handshake, held until taken
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_data <= rd_mux;
		end
	end

	// bus outputs
	always_comb begin
		axi_rsp.aw_ready = wr_fire;
		axi_rsp.w_ready  = wr_fire;
		axi_rsp.b_valid  = b_valid;
		axi_rsp.b_resp   = b_resp;
		axi_rsp.ar_ready = ar_ready;
		axi_rsp.r_valid  = r_valid;
		axi_rsp.r_data   = r_data;
		// every readable offset is mapped
		axi_rsp.r_resp   = OKAY;
	end

	// operands into the adder path
	always_comb begin
		operands.a   = reg_a;
		operands.b   = reg_b;
		operands.sub = reg_ctrl.sub;
	end

	// write response must stay up and unchanged until b ready
	assert property (@(posedge clk) disable iff (!rst_n)
		b_valid && !axi_req.b_ready |=> b_valid && $stable(b_resp));

	// read data must stay up and unchanged until r ready
	assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !axi_req.r_ready |=> r_valid && $stable(r_data));

	// master only issues full-word writes
	assert property (@(posedge clk) disable iff (!rst_n)
		wr_fire |-> axi_req.w_strb == '1);

endmodule

// ==== verilog/lau_top.sv ====
// arithmetic unit top level
// axi4-lite register slave plus combinational adder-subtractor

`include "lau_cfg.svh"

module lau_top #(
	parameter lau_pkg::speed_e speed = `LAU_SPEED_DEFAULT
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  axi_lite_pkg::axi_lite_req_t axi_req,
	output axi_lite_pkg::axi_lite_rsp_t axi_rsp
);
	import lau_pkg::*;

	// register contents to the adder
	lau_operands_t operands;
	// sum back to the read mux
	logic [`LAU_WIDTH-1:0] result;

	// bus slave and operand storage
	lau_regs i_lau_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.axi_req  (axi_req),
		.axi_rsp  (axi_rsp),
		.operands (operands),
		.result   (result)
	);

	// zero-latency arithmetic
	add_sub #(
		.width (`LAU_WIDTH),
		.speed (speed)
	) i_add_sub (
		.a   (operands.a),
		.b   (operands.b),
		.sub (operands.sub),
		.s   (result)
	);

endmodule

// ==== verilog/prefix_and_or.sv ====
// parallel-prefix and-or tree for generate/propagate pairs
// serial chain, brent-kung style tree or sklansky tree by speed
// bit i of go/po covers bits i down to 0

module prefix_and_or #(
	parameter int              width = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);
	import lau_pkg::*;

	// number of tree levels
	localparam int lvls = $clog2(width);

	if (speed == SLOW) begin : g_serial
		// ripple chain, depth grows with width
		assign go[0] = gi[0];
		assign po[0] = pi[0];
		for (genvar i = 1; i < width; i++) begin : g_bit
			assign go[i] = gi[i] | (pi[i] & go[i-1]);
			assign po[i] = pi[i] & po[i-1];
		end
	end else if (speed == MEDIUM) begin : g_brent_kung
		// up sweep in stages 1..lvls, down sweep after that
		localparam int last = (lvls > 0) ? 2 * lvls - 1 : 0;

		logic [width-1:0] g [0:last];
		logic [width-1:0] p [0:last];

		assign g[0] = gi;
		assign p[0] = pi;

		// up sweep, blocks of 2^l ending at i
		for (genvar l = 1; l <= lvls; l++) begin : g_up
			for (genvar i = 0; i < width; i++) begin : g_bit
				if ((i + 1) % (1 << l) == 0) begin : g_node
					assign g[l][i] = g[l-1][i] | (p[l-1][i] & g[l-1][i-(1<<(l-1))]);
					assign p[l][i] = p[l-1][i] & p[l-1][i-(1<<(l-1))];
				end else begin : g_pass
					assign g[l][i] = g[l-1][i];
					assign p[l][i] = p[l-1][i];
				end
			end
		end

		// down sweep fills the positions between the finished ones
		for (genvar d = 1; d < lvls; d++) begin : g_down
			localparam int l = lvls - d;
			localparam int s = lvls + d;
			for (genvar i = 0; i < width; i++) begin : g_bit
				if (i >= (1 << l) && (i + 1) % (1 << l) == (1 << (l - 1))) begin : g_node
					// left neighbour already holds its full prefix
					assign g[s][i] = g[s-1][i] | (p[s-1][i] & g[s-1][i-(1<<(l-1))]);
					assign p[s][i] = p[s-1][i] & p[s-1][i-(1<<(l-1))];
				end else begin : g_pass
					assign g[s][i] = g[s-1][i];
					assign p[s][i] = p[s-1][i];
				end
			end
		end

		assign go = g[last];
		assign po = p[last];
	end else begin : g_sklansky
		// divide and conquer, log depth, high fan-out
		logic [width-1:0] g [0:lvls];
		logic [width-1:0] p [0:lvls];

		assign g[0] = gi;
		assign p[0] = pi;

		for (genvar l = 1; l <= lvls; l++) begin : g_lvl
			for (genvar i = 0; i < width; i++) begin : g_bit
				// upper half of each 2^l block takes the top of the lower half
				if (((i >> (l - 1)) & 1) == 1) begin : g_node
					localparam int j = ((i >> (l - 1)) << (l - 1)) - 1;
					assign g[l][i] = g[l-1][i] | (p[l-1][i] & g[l-1][j]);
					assign p[l][i] = p[l-1][i] & p[l-1][j];
				end else begin : g_pass
					assign g[l][i] = g[l-1][i];
					assign p[l][i] = p[l-1][i];
				end
			end
		end

		assign go = g[lvls];
		assign po = p[lvls];
	end

endmodule
